//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_fpu
FILELIST  ?= verilog.f
PASS_MSG  := Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- tests/fpu_assert.sv
`timescale 1ns/1ps

module fpu_assert (
    input logic       clk,
    input logic       rstn,
    input logic [1:0] hold_v,
    input logic [1:0] load,
    input logic       wr_en
);

    // issues are 2 cycles apart so a hold drains before its pipe finishes again
    a_hold_free: assert property (@(posedge clk) disable iff (!rstn)
        (load & hold_v) == 2'b00)
        else $error("result hold loaded while still full");

    // the loser of a conflict wins the next cycle
    a_hold_drain: assert property (@(posedge clk) disable iff (!rstn)
        hold_v != 2'b00 |=> (hold_v & $past(hold_v)) == 2'b00)
        else $error("held result not written in the following cycle");

    a_reset_quiet: assert property (@(posedge clk) $rose(rstn) |-> !wr_en)
        else $error("write port active right after reset");

endmodule

bind result_arbiter fpu_assert u_fpu_assert (
    .clk    (clk),
    .rstn   (rstn),
    .hold_v (hold_v),
    .load   (load),
    .wr_en  (wr_en)
);

//--- tests/tb_fpu.sv
`timescale 1ns/1ps

module tb_fpu import fpu_pkg::*; ();

    localparam int ACK_LIMIT  = 16;   // cycles
    localparam int POLL_LIMIT = 12;   // status reads

    logic       clk;
    logic       rstn;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [3:0] wb_adr;
    float_t     wb_dat_i;
    float_t     wb_dat_o;
    logic       wb_ack;

    logic [31:0] lfsr;
    int          n_chk;
    int          n_err;

    fpu_top #(.N_SLOTS(8)) u_fpu_top (
        .clk      (clk),
        .rstn     (rstn),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    always #5 clk = ~clk;

    //////////////////////////////
    // stimulus and reference models

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic float_t rand_float();
        logic [31:0] s;
        logic [31:0] e;
        logic [31:0] m;
        s = lfsr_bits(1);
        e = lfsr_bits(6);
        m = lfsr_bits(23);
        return {s[0], exp_t'(32'd100 + e % 32'd55), m[22:0]};   // exponent 100..154
    endfunction

    function automatic float_t fmul_model(input float_t a, input float_t b);
        logic        s;
        logic [47:0] p;
        mant_t       m;
        int          e;
        s = a[31] ^ b[31];
        p = {24'b0, 1'b1, a[22:0]} * {24'b0, 1'b1, b[22:0]};
        e = int'(a[30:23]) + int'(b[30:23]) - 127;
        if (p[47]) begin
            m = p[46:24];
            e = e + 1;
        end else begin
            m = p[45:23];   // truncated
        end
        if (a[30:23] == 8'd0 || b[30:23] == 8'd0 || e <= 0) begin
            return {s, 31'b0};
        end else if (e >= 255) begin
            return {s, 8'hff, m};
        end
        return {s, exp_t'(e), m};
    endfunction

    function automatic real float_to_real(input float_t f);
        logic [63:0] d;
        if (f[30:23] == 8'd0) begin
            d = {f[31], 63'b0};
        end else begin
            d = {f[31], 11'(f[30:23]) + 11'd896, f[22:0], 29'b0};   // rebias 127 -> 1023
        end
        return $bitstoreal(d);
    endfunction

    // nearest single precision value of a double
    function automatic float_t real_to_float(input real r);
        logic [63:0] d;
        logic [30:0] mag;
        d   = $realtobits(r);
        mag = {8'(d[62:52] - 11'd896), d[51:29]} + 31'(d[28]);
        return {d[63], mag};
    endfunction

    function automatic float_t fdiv_model(input float_t a, input float_t b);
        return real_to_float(float_to_real(a) / float_to_real(b));
    endfunction

    //////////////////////////////
    // compare tasks

    task automatic check_float(input string name, input float_t got, input float_t want);
        n_chk++;
        if (got !== want) begin
            n_err++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_float_near(input string name, input float_t got, input float_t want);
        int diff;
        n_chk++;
        diff = int'(got[30:0]) - int'(want[30:0]);
        if ($isunknown(got) || got[31] != want[31] || diff > 2 || diff < -2) begin
            n_err++;
            $display("** Error at %0t ns: %s = %h, expected %h within 2 ulp",
                     $time, name, got, want);
        end
    endtask

    task automatic check_exp(input string name, input exp_t got, input exp_t want);
        n_chk++;
        if (got !== want) begin
            n_err++;
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        n_chk++;
        if (got !== want) begin
            n_err++;
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, want);
        end
    endtask

    //////////////////////////////
    // bus tasks

    task automatic bus_idle();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    // called 1 ns after an edge, returns 1 ns after the ack edge
    task automatic wait_ack(input logic [3:0] adr);
        int cnt;
        cnt = 0;
        @(posedge clk);
        #1;
        while (!wb_ack && cnt < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!wb_ack) begin
            n_err++;
            $display("timeout at %0t ns: no wb_ack for address %0d", $time, adr);
        end
    endtask

    task automatic wb_write(input logic [3:0] adr, input float_t data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_i = data;
        wait_ack(adr);
        bus_idle();
    endtask

    task automatic wb_read(input logic [3:0] adr, output float_t data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack(adr);
        data = wb_dat_o;   // valid while ack is high
        bus_idle();
    endtask

    task automatic wait_slot(input logic [2:0] slot);
        float_t st;
        int     cnt;
        cnt = 0;
        st  = '0;
        while (st[slot] !== 1'b1 && cnt < POLL_LIMIT) begin
            wb_read(REG_STATUS, st);
            cnt++;
        end
        if (st[slot] !== 1'b1) begin
            n_err++;
            $display("timeout at %0t ns: slot %0d never reported a result", $time, slot);
        end
    endtask

    task automatic issue_op(input fpu_op_t op, input logic [2:0] slot);
        float_t cmd;
        cmd                    = '0;
        cmd[CMD_OP_BIT]        = op;
        cmd[CMD_SLOT_LSB +: 3] = slot;
        wb_write(REG_CMD, cmd);
    endtask

    task automatic run_op(input fpu_op_t op, input float_t a, input float_t b,
                          input logic [2:0] slot, output float_t r);
        wb_write(REG_OPA, a);
        wb_write(REG_OPB, b);
        issue_op(op, slot);
        wait_slot(slot);
        wb_read(REG_RES_BASE + 4'(slot), r);
    endtask

    task automatic report_test(input string name, input int cases, input int err0);
        $display("test %s: %0d cases, %0d errors", name, cases, n_err - err0);
    endtask

    //////////////////////////////
    // tests

    task automatic test_mul_random();
        int     err0;
        float_t a, b, r;
        err0 = n_err;
        for (int i = 0; i < 20; i++) begin
            a = rand_float();
            b = rand_float();
            run_op(OP_MUL, a, b, 3'(i), r);
            check_float($sformatf("product %0d", i), r, fmul_model(a, b));
        end
        report_test("multiply", 20, err0);
    endtask

    task automatic test_div_pow2();
        int     err0;
        float_t a, b, r;
        err0 = n_err;
        for (int i = 0; i < 10; i++) begin
            a        = rand_float();
            b        = rand_float();
            b[22:0]  = '0;   // divisor is a power of two
            run_op(OP_DIV, a, b, 3'(i), r);
            check_float($sformatf("quotient %0d", i), r, fdiv_model(a, b));
        end
        report_test("divide by power of two", 10, err0);
    endtask

    task automatic test_div_random();
        int     err0;
        float_t a, b, r;
        err0 = n_err;
        for (int i = 0; i < 20; i++) begin
            a = rand_float();
            b = rand_float();
            run_op(OP_DIV, a, b, 3'(i), r);
            check_float_near($sformatf("quotient %0d", i), r, fdiv_model(a, b));
        end
        report_test("divide", 20, err0);
    endtask

    task automatic test_div_clamp();
        int     err0;
        float_t a, b, r;
        err0 = n_err;
        for (int i = 0; i < 2; i++) begin
            a        = rand_float();
            b        = rand_float();
            a[30:23] = 8'd10;
            b[30:23] = 8'd200;
            run_op(OP_DIV, a, b, 3'(2 * i), r);
            check_exp("underflow exponent", r[30:23], 8'h00);
            a[30:23] = 8'd240;
            b[30:23] = 8'd20;
            run_op(OP_DIV, a, b, 3'(2 * i + 1), r);
            check_exp("overflow exponent", r[30:23], 8'hff);
        end
        report_test("exponent clamp", 4, err0);
    endtask

    task automatic test_shared_port();
        int     err0;
        float_t a, b, r, st;
        err0 = n_err;
        a    = rand_float();
        b    = rand_float();
        wb_write(REG_OPA, a);
        wb_write(REG_OPB, b);
        issue_op(OP_DIV, 3'd5);
        issue_op(OP_MUL, 3'd6);   // 2 cycles later, same finish cycle
        wait_slot(3'd5);
        wait_slot(3'd6);
        wb_read(REG_RES_BASE + 4'd5, r);
        check_float_near("slot 5 quotient", r, fdiv_model(a, b));
        wb_read(REG_RES_BASE + 4'd6, r);
        check_float("slot 6 product", r, fmul_model(a, b));

        // reissue both, each bit drops before the new result lands
        issue_op(OP_DIV, 3'd5);
        wb_read(REG_STATUS, st);
        check_bit("status[5]", st[5], 1'b0);
        issue_op(OP_DIV, 3'd6);
        wb_read(REG_STATUS, st);
        check_bit("status[6]", st[6], 1'b0);
        wait_slot(3'd5);
        wait_slot(3'd6);
        wb_read(REG_RES_BASE + 4'd5, r);
        check_float_near("slot 5 quotient", r, fdiv_model(a, b));
        wb_read(REG_RES_BASE + 4'd6, r);
        check_float_near("slot 6 quotient", r, fdiv_model(a, b));
        report_test("shared write port", 2, err0);
    endtask

    initial begin
        clk      = 1'b0;
        rstn     = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        lfsr     = 32'hb0f49c2d;
        n_chk    = 0;
        n_err    = 0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_mul_random();
        test_div_pow2();
        test_div_random();
        test_div_clamp();
        test_shared_port();

        $display("%0d checks, %0d errors", n_chk, n_err);
        if (n_err == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
verilog/fpu_pkg.sv
verilog/finv_pipe.sv
verilog/fmul_pipe.sv
verilog/fdiv_pipe.sv
verilog/result_arbiter.sv
verilog/fpu_wb_regs.sv
verilog/fpu_top.sv
tests/fpu_assert.sv
tests/tb_fpu.sv

//--- verilog/fdiv_pipe.sv
`timescale 1ns/1ps

module fdiv_pipe import fpu_pkg::*; #(
    parameter  int N_SLOTS = 8,
    localparam int TAG_W   = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             in_valid,
    input  float_t           x,
    input  float_t           y,
    input  logic [TAG_W-1:0] tag,
    output logic             out_valid,
    output float_t           res,
    output logic [TAG_W-1:0] out_tag
);

    logic  sx, sy;
    exp_t  ex, ey;
    mant_t mx, my;

    assign {sx, ex, mx} = x;
    assign {sy, ey, my} = y;

    float_t inv;   // 1/1.my, exponent 126 or 127

    finv_pipe u_finv (
        .clk  (clk),
        .rstn (rstn),
        .m    (my),
        .res  (inv)
    );

    //////////////////////////////
    // alignment registers

    logic             v_d1, v_d2;
    logic [TAG_W-1:0] tag_d1, tag_d2;
    logic             s_d1, s_d2, s_d3, s_d4;
    exp_t             ex_d1, ex_d2, ex_d3, ex_d4;
    exp_t             ey_d1, ey_d2, ey_d3, ey_d4;
    mant_t            mx_d1, mx_d2;
    logic             inv_odd_d3, inv_odd_d4;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            v_d1 <= 1'b0;
            v_d2 <= 1'b0;
        end else begin
            v_d1 <= in_valid;
            v_d2 <= v_d1;
        end
    end

    always_ff @(posedge clk) begin
        tag_d1     <= tag;
        tag_d2     <= tag_d1;
        s_d1       <= sx ^ sy;
        s_d2       <= s_d1;
        s_d3       <= s_d2;
        s_d4       <= s_d3;
        ex_d1      <= ex;
        ex_d2      <= ex_d1;
        ex_d3      <= ex_d2;
        ex_d4      <= ex_d3;
        ey_d1      <= ey;
        ey_d2      <= ey_d1;
        ey_d3      <= ey_d2;
        ey_d4      <= ey_d3;
        mx_d1      <= mx;
        mx_d2      <= mx_d1;
        inv_odd_d3 <= inv[23];   // reciprocal exponent lsb
        inv_odd_d4 <= inv_odd_d3;
    end

    //////////////////////////////
    // mantissa product

    float_t mul_x, mul_y, mul_res;

    assign mul_x = {1'b0, EXP_BIAS, mx_d2};
    assign mul_y = {1'b0, EXP_BIAS, inv[22:0]};

    fmul_pipe #(.N_SLOTS(N_SLOTS)) u_fmul (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (v_d2),
        .x         (mul_x),
        .y         (mul_y),
        .tag       (tag_d2),
        .out_valid (out_valid),
        .res       (mul_res),
        .out_tag   (out_tag)
    );

    logic signed [9:0] e_adj;
    logic signed [9:0] e_tmp;

    always_comb begin
        case ({inv_odd_d4, mul_res[23]})
            2'b10:   e_adj = 10'sd128;
            2'b01:   e_adj = 10'sd126;
            default: e_adj = 10'sd127;
        endcase
        e_tmp = $signed({2'b0, ex_d4}) - $signed({2'b0, ey_d4}) + e_adj;
        if (e_tmp <= 10'sd0) begin
            res = {s_d4, 31'b0};                      // underflow
        end else if (e_tmp >= 10'sd255) begin
            res = {s_d4, 8'hff, mul_res[22:0]};       // overflow
        end else begin
            res = {s_d4, e_tmp[7:0], mul_res[22:0]};
        end
    end

endmodule

//--- verilog/finv_pipe.sv
`timescale 1ns/1ps

module finv_pipe import fpu_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  mant_t  m,
    output float_t res
);

    typedef logic [15:0][30:0] tbl_t;

    // r = 1/d at the middle of each of the 16 segments, q0.30
    function automatic tbl_t build_tbl(input logic sq);
        tbl_t        t;
        logic [63:0] r;
        for (int i = 0; i < 16; i++) begin
            r = (64'd1 << 35) / (64'd33 + 64'(2 * i));
            t[i] = sq ? 31'((r * r) >> 30) : 31'(r);
        end
        return t;
    endfunction

    localparam tbl_t SEED    = build_tbl(1'b0);
    localparam tbl_t SEED_SQ = build_tbl(1'b1);   // r squared, slope of the seed

    //////////////////////////////
    // stage 1: seed

    logic [3:0]         idx;
    logic signed [20:0] dlt;    // offset from segment middle, 2^-23 units
    logic signed [52:0] corr;
    logic signed [52:0] x0_w;
    logic [30:0]        x0_q;
    mant_t              m_q;

    assign idx = m[22:19];

    always_comb begin
        dlt  = $signed({2'b0, m[18:0]}) - 21'sd262144;
        corr = $signed({22'b0, SEED_SQ[idx]}) * dlt;
        // first order seed, nudged low so it never overshoots 1/d
        x0_w = $signed({22'b0, SEED[idx]}) - (corr >>> 23) - 53'sd2;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            x0_q <= '0;
            m_q  <= '0;
        end else begin
            x0_q <= x0_w[30:0];
            m_q  <= m;
        end
    end

    //////////////////////////////
    // stage 2: refinement

    logic [30:0] d_fix;   // 1.m in q1.30
    logic [61:0] p;
    logic [61:0] e_full;
    logic [31:0] e;       // residual 1 - d*x0
    logic [63:0] ee;
    logic [31:0] f;
    logic [62:0] q;
    logic [30:0] x1;

    always_comb begin
        d_fix  = {1'b1, m_q, 7'b0};
        p      = d_fix * x0_q;
        e_full = (62'd1 << 60) - p;
        e      = e_full[61:30];
        ee     = e * e;
        f      = (32'd1 << 30) + e + ee[61:30];   // 1 + e + e^2
        q      = x0_q * f;
        x1     = q[60:30] + 31'd32;                // round at mantissa lsb
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            res <= '0;
        end else if (m_q == '0) begin
            res <= {1'b0, EXP_BIAS, 23'b0};              // 1/1.0 is exact
        end else begin
            res <= {1'b0, EXP_BIAS - 8'd1, x1[28:6]};    // value in (0.5, 1)
        end
    end

endmodule

//--- verilog/fmul_pipe.sv
`timescale 1ns/1ps

module fmul_pipe import fpu_pkg::*; #(
    parameter  int N_SLOTS = 8,
    localparam int TAG_W   = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             in_valid,
    input  float_t           x,
    input  float_t           y,
    input  logic [TAG_W-1:0] tag,
    output logic             out_valid,
    output float_t           res,
    output logic [TAG_W-1:0] out_tag
);

    logic  sx, sy;
    exp_t  ex, ey;
    mant_t mx, my;

    assign {sx, ex, mx} = x;
    assign {sy, ey, my} = y;

    //////////////////////////////
    // stage 1

    logic             s1_valid;
    logic [TAG_W-1:0] s1_tag;
    logic             s1_sign;
    logic             s1_zero;
    logic [8:0]       s1_esum;
    logic [47:0]      s1_prod;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_tag  <= tag;
        s1_sign <= sx ^ sy;
        s1_zero <= (ex == '0) || (ey == '0);   // denormal or zero operand
        s1_esum <= {1'b0, ex} + {1'b0, ey};
        s1_prod <= {1'b1, mx} * {1'b1, my};
    end

    //////////////////////////////
    // stage 2

    logic signed [9:0] e_norm;
    mant_t             m_norm;
    float_t            res_d;

    always_comb begin
        e_norm = $signed({1'b0, s1_esum}) - $signed({2'b0, EXP_BIAS})
               + $signed({9'b0, s1_prod[47]});
        m_norm = s1_prod[47] ? s1_prod[46:24] : s1_prod[45:23];   // truncate
        if (s1_zero || e_norm <= 10'sd0) begin
            res_d = {s1_sign, 31'b0};
        end else if (e_norm >= 10'sd255) begin
            res_d = {s1_sign, 8'hff, m_norm};   // overflow, exponent saturates
        end else begin
            res_d = {s1_sign, e_norm[7:0], m_norm};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        res     <= res_d;
        out_tag <= s1_tag;
    end

endmodule

//--- verilog/fpu_pkg.sv
package fpu_pkg;

    //////////////////////////////
    // float fields

    typedef logic [31:0] float_t;   // ieee single precision word
    typedef logic [7:0]  exp_t;     // biased exponent
    typedef logic [22:0] mant_t;    // stored mantissa, hidden one dropped

    localparam exp_t EXP_BIAS = 8'd127;

    //////////////////////////////
    // operations

    typedef enum logic {
        OP_MUL = 1'b0,
        OP_DIV = 1'b1
    } fpu_op_t;

    //////////////////////////////
    // register map, word addresses

    localparam logic [3:0] REG_OPA      = 4'd0;
    localparam logic [3:0] REG_OPB      = 4'd1;
    localparam logic [3:0] REG_CMD      = 4'd2;
    localparam logic [3:0] REG_STATUS   = 4'd3;
    localparam logic [3:0] REG_RES_BASE = 4'd8;   // slot n at base + n

    // command word fields
    localparam int CMD_OP_BIT   = 0;
    localparam int CMD_SLOT_LSB = 4;   // slot in bits 7:4

endpackage

//--- verilog/fpu_top.sv
`timescale 1ns/1ps

module fpu_top import fpu_pkg::*; #(
    parameter  int N_SLOTS = 8,
    localparam int TAG_W   = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [3:0] wb_adr,
    input  float_t     wb_dat_i,
    output float_t     wb_dat_o,
    output logic       wb_ack
);

    float_t           opa, opb;
    logic [TAG_W-1:0] issue_tag;
    logic             mul_issue, div_issue;

    logic             mul_valid, div_valid;
    logic [TAG_W-1:0] mul_tag, div_tag;
    float_t           mul_res, div_res;

    logic             wr_en;
    logic [TAG_W-1:0] wr_tag;
    float_t           wr_data;

    fpu_wb_regs #(.N_SLOTS(N_SLOTS)) u_regs (
        .clk       (clk),
        .rstn      (rstn),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack    (wb_ack),
        .opa       (opa),
        .opb       (opb),
        .issue_tag (issue_tag),
        .mul_issue (mul_issue),
        .div_issue (div_issue),
        .wr_en     (wr_en),
        .wr_tag    (wr_tag),
        .wr_data   (wr_data)
    );

    // 2 cycle multiplier
    fmul_pipe #(.N_SLOTS(N_SLOTS)) u_fmul (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (mul_issue),
        .x         (opa),
        .y         (opb),
        .tag       (issue_tag),
        .out_valid (mul_valid),
        .res       (mul_res),
        .out_tag   (mul_tag)
    );

    // 4 cycle divider
    fdiv_pipe #(.N_SLOTS(N_SLOTS)) u_fdiv (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (div_issue),
        .x         (opa),
        .y         (opb),
        .tag       (issue_tag),
        .out_valid (div_valid),
        .res       (div_res),
        .out_tag   (div_tag)
    );

    result_arbiter #(.N_SLOTS(N_SLOTS)) u_arb (
        .clk       (clk),
        .rstn      (rstn),
        .mul_valid (mul_valid),
        .mul_tag   (mul_tag),
        .mul_res   (mul_res),
        .div_valid (div_valid),
        .div_tag   (div_tag),
        .div_res   (div_res),
        .wr_en     (wr_en),
        .wr_tag    (wr_tag),
        .wr_data   (wr_data)
    );

endmodule

//--- verilog/fpu_wb_regs.sv
`timescale 1ns/1ps

module fpu_wb_regs import fpu_pkg::*; #(
    parameter  int N_SLOTS = 8,
    localparam int TAG_W   = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1
) (
    input  logic             clk,
    input  logic             rstn,
    // wishbone classic slave
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [3:0]       wb_adr,
    input  float_t           wb_dat_i,
    output float_t           wb_dat_o,
    output logic             wb_ack,
    // issue to the pipelines
    output float_t           opa,
    output float_t           opb,
    output logic [TAG_W-1:0] issue_tag,
    output logic             mul_issue,
    output logic             div_issue,
    // result write port
    input  logic             wr_en,
    input  logic [TAG_W-1:0] wr_tag,
    input  float_t           wr_data
);

    logic             req;
    logic             wr_req;
    logic             cmd_wr;
    fpu_op_t          cmd_op;
    logic [TAG_W-1:0] cmd_slot;
    logic [3:0]       res_off;
    logic [N_SLOTS-1:0] status;   // new result not yet reissued
    float_t           mem [N_SLOTS];
    float_t           rd_data;

    assign req      = wb_cyc & wb_stb & ~wb_ack;   // one transfer per ack
    assign wr_req   = req & wb_we;
    assign cmd_wr   = wr_req & (wb_adr == REG_CMD);
    assign cmd_op   = fpu_op_t'(wb_dat_i[CMD_OP_BIT]);
    assign cmd_slot = wb_dat_i[CMD_SLOT_LSB +: TAG_W];
    assign res_off  = wb_adr - REG_RES_BASE;

    //////////////////////////////
    // control

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_ack    <= 1'b0;
            mul_issue <= 1'b0;
            div_issue <= 1'b0;
            status    <= '0;
        end else begin
            wb_ack    <= req;
            mul_issue <= cmd_wr & (cmd_op == OP_MUL);
            div_issue <= cmd_wr & (cmd_op == OP_DIV);
            if (wr_en) begin
                status[wr_tag] <= 1'b1;
            end
            if (cmd_wr) begin
                status[cmd_slot] <= 1'b0;   // reissue wins over a late finish
            end
        end
    end

    //////////////////////////////
    // data

    always_ff @(posedge clk) begin
        if (wr_req && wb_adr == REG_OPA) begin
            opa <= wb_dat_i;
        end
        if (wr_req && wb_adr == REG_OPB) begin
            opb <= wb_dat_i;
        end
        if (cmd_wr) begin
            issue_tag <= cmd_slot;
        end
        if (req && !wb_we) begin
            wb_dat_o <= rd_data;   // held for the ack cycle
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_tag] <= wr_data;
        end
    end

    always_comb begin
        rd_data = '0;
        if (wb_adr >= REG_RES_BASE) begin
            rd_data = mem[res_off[TAG_W-1:0]];
        end else begin
            case (wb_adr)
                REG_OPA:    rd_data = opa;
                REG_OPB:    rd_data = opb;
                REG_STATUS: rd_data[N_SLOTS-1:0] = status;
                default:    rd_data = '0;   // command is write only
            endcase
        end
    end

endmodule

//--- verilog/result_arbiter.sv
`timescale 1ns/1ps

module result_arbiter import fpu_pkg::*; #(
    parameter  int N_SLOTS = 8,
    localparam int TAG_W   = (N_SLOTS > 1) ? $clog2(N_SLOTS) : 1
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             mul_valid,
    input  logic [TAG_W-1:0] mul_tag,
    input  float_t           mul_res,
    input  logic             div_valid,
    input  logic [TAG_W-1:0] div_tag,
    input  float_t           div_res,
    output logic             wr_en,
    output logic [TAG_W-1:0] wr_tag,
    output float_t           wr_data
);

    // requester 0 is the multiplier, 1 the divider
    logic [1:0]       in_v;
    logic [TAG_W-1:0] in_tag [2];
    float_t           in_res [2];

    logic [1:0]       hold_v;
    logic [TAG_W-1:0] hold_tag [2];
    float_t           hold_res [2];

    logic [TAG_W-1:0] cand_tag [2];
    float_t           cand_res [2];
    logic [1:0]       req, grant, load;
    logic             rr;   // divider has priority when set

    assign in_v      = {div_valid, mul_valid};
    assign in_tag[0] = mul_tag;
    assign in_tag[1] = div_tag;
    assign in_res[0] = mul_res;
    assign in_res[1] = div_res;

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cand_tag[i] = hold_v[i] ? hold_tag[i] : in_tag[i];   // held result goes first
            cand_res[i] = hold_v[i] ? hold_res[i] : in_res[i];
        end
        req      = hold_v | in_v;
        grant[0] = req[0] & (~req[1] | ~rr);
        grant[1] = req[1] & (~req[0] | rr);
        load     = in_v & (hold_v | ~grant);   // live result not written now
    end

    assign wr_en   = |req;
    assign wr_tag  = grant[1] ? cand_tag[1] : cand_tag[0];
    assign wr_data = grant[1] ? cand_res[1] : cand_res[0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            hold_v <= '0;
            rr     <= 1'b0;
        end else begin
            hold_v <= (hold_v & ~grant) | load;
            if (&req) begin
                rr <= ~rr;   // loser wins the next conflict
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (load[i]) begin
                hold_tag[i] <= in_tag[i];
                hold_res[i] <= in_res[i];
            end
        end
    end

endmodule
